/* common/adder_config.svh */
`ifndef ADDER_CONFIG_SVH
`define ADDER_CONFIG_SVH

// width of one prefix block
`define ADDER_HALF_WIDTH 32

// two blocks side by side
`define ADDER_WIDTH 64

// encoder plus three merge stages
`define ADDER_PIPE_DEPTH 4

`endif

/* common/adder_pkg.sv */
`include "adder_config.svh"

package adder_pkg;

    // upper bit: carry possible, lower bit: carry certain
    typedef enum logic [1:0] {
        STATUS_KILL      = 2'b00,
        STATUS_PROPAGATE = 2'b10,
        STATUS_GENERATE  = 2'b11
    } carry_status_e;

    typedef carry_status_e [`ADDER_HALF_WIDTH-1:0] status_vec_t;

    typedef logic [`ADDER_HALF_WIDTH-1:0] half_word_t;

    // propagate defers to the span below, kill and generate decide on their own
    function automatic carry_status_e merge_status(
        input carry_status_e upper,
        input carry_status_e lower
    );
        return (upper == STATUS_PROPAGATE) ? lower : upper;
    endfunction

endpackage

/* common/prefix_stage_if.sv */
`timescale 1ns/1ps

interface prefix_stage_if
    import adder_pkg::*;
();

    status_vec_t status;
    half_word_t  a;
    half_word_t  b;
    logic        cin;

    // written by the registers of one stage
    modport source (
        output status,
        output a,
        output b,
        output cin
    );

    // read by the next stage
    modport sink (
        input status,
        input a,
        input b,
        input cin
    );

endinterface

/* prefix_adder/status_encoder.sv */
`timescale 1ns/1ps
`include "adder_config.svh"

module status_encoder
    import adder_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  half_word_t            a,
    input  half_word_t            b,
    input  logic                  cin,
    prefix_stage_if.source        out
);

    status_vec_t next_status;
    logic        carry_low;

    // position 0 absorbs the carry-in, so it is never left as propagate
    assign carry_low = (a[0] & b[0]) | (a[0] & cin) | (b[0] & cin);

    always_comb
    begin
        next_status[0] = carry_low ? STATUS_GENERATE : STATUS_KILL;
        for (int i = 1; i < `ADDER_HALF_WIDTH; i++)
        begin
            if (a[i] & b[i])
                next_status[i] = STATUS_GENERATE;
            else if (a[i] ^ b[i])
                next_status[i] = STATUS_PROPAGATE;
            else
                next_status[i] = STATUS_KILL;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `ADDER_HALF_WIDTH; i++)
                out.status[i] <= STATUS_KILL;
            out.a   <= '0;
            out.b   <= '0;
            out.cin <= 1'b0;
        end
        else
        begin
            out.status <= next_status;
            out.a      <= a;
            out.b      <= b;
            out.cin    <= cin;
        end
    end

endmodule

/* prefix_adder/prefix_stage.sv */
`timescale 1ns/1ps
`include "adder_config.svh"

module prefix_stage
    import adder_pkg::*;
#(
    parameter int FIRST_SPAN = 1,
    parameter int LEVELS     = 1
)
(
    input  logic           clk,
    input  logic           reset,
    prefix_stage_if.sink   up,
    prefix_stage_if.source down
);

    // level 0 is the registered input, level LEVELS goes into the register
    status_vec_t level_status [0:LEVELS];

    assign level_status[0] = up.status;

    for (genvar l = 0; l < LEVELS; l++)
    begin : g_level
        // span doubles with every level
        localparam int SPAN = FIRST_SPAN << l;

        for (genvar i = 0; i < `ADDER_HALF_WIDTH; i++)
        begin : g_pos
            if (i >= SPAN)
            begin : g_merge
                assign level_status[l+1][i] = merge_status(
                    level_status[l][i],
                    level_status[l][i-SPAN]
                );
            end
            else
            begin : g_pass
                // already resolved down to bit 0
                assign level_status[l+1][i] = level_status[l][i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `ADDER_HALF_WIDTH; i++)
                down.status[i] <= STATUS_KILL;
        end
        else
        begin
            down.status <= level_status[LEVELS];
        end
    end

    // operands ride along for the sum at the end of the pipe
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            down.a   <= '0;
            down.b   <= '0;
            down.cin <= 1'b0;
        end
        else
        begin
            down.a   <= up.a;
            down.b   <= up.b;
            down.cin <= up.cin;
        end
    end

endmodule

/* prefix_adder/prefix_adder32.sv */
`timescale 1ns/1ps
`include "adder_config.svh"

module prefix_adder32
    import adder_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  half_word_t a,
    input  half_word_t b,
    input  logic       cin,
    output half_word_t sum,
    output logic       cout
);

    prefix_stage_if enc_to_s1 ();
    prefix_stage_if s1_to_s2 ();
    prefix_stage_if s2_to_s3 ();
    prefix_stage_if s3_out ();

    logic [`ADDER_HALF_WIDTH-1:0] carry_out;

    // cycle 1
    status_encoder i_status_encoder (
        .clk   (clk),
        .reset (reset),
        .a     (a),
        .b     (b),
        .cin   (cin),
        .out   (enc_to_s1.source)
    );

    // spans 1 and 2, cycle 2
    prefix_stage #(.FIRST_SPAN(1), .LEVELS(2)) i_stage_span1 (
        .clk   (clk),
        .reset (reset),
        .up    (enc_to_s1.sink),
        .down  (s1_to_s2.source)
    );

    // spans 4 and 8, cycle 3
    prefix_stage #(.FIRST_SPAN(4), .LEVELS(2)) i_stage_span4 (
        .clk   (clk),
        .reset (reset),
        .up    (s1_to_s2.sink),
        .down  (s2_to_s3.source)
    );

    // span 16, cycle 4
    prefix_stage #(.FIRST_SPAN(16), .LEVELS(1)) i_stage_span16 (
        .clk   (clk),
        .reset (reset),
        .up    (s2_to_s3.sink),
        .down  (s3_out.source)
    );

    // every status is resolved now, generate means a carry leaves that bit
    always_comb
    begin
        for (int i = 0; i < `ADDER_HALF_WIDTH; i++)
            carry_out[i] = (s3_out.status[i] == STATUS_GENERATE);
    end

    assign sum  = s3_out.a ^ s3_out.b ^ {carry_out[`ADDER_HALF_WIDTH-2:0], s3_out.cin};
    assign cout = carry_out[`ADDER_HALF_WIDTH-1];

endmodule

/* rtl/adder64_top.sv */
`timescale 1ns/1ps
`include "adder_config.svh"

module adder64_top
    import adder_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`ADDER_WIDTH-1:0] a,
    input  logic [`ADDER_WIDTH-1:0] b,
    input  logic                    cin,
    output logic [`ADDER_WIDTH-1:0] sum,
    output logic                    cout
);

    half_word_t sum_low;
    half_word_t sum_high_c0;
    half_word_t sum_high_c1;
    logic       cout_low;
    logic       cout_high_c0;
    logic       cout_high_c1;

    prefix_adder32 lower_adder (
        .clk   (clk),
        .reset (reset),
        .a     (a[`ADDER_HALF_WIDTH-1:0]),
        .b     (b[`ADDER_HALF_WIDTH-1:0]),
        .cin   (cin),
        .sum   (sum_low),
        .cout  (cout_low)
    );

    // both guesses for the upper half run alongside the lower half
    prefix_adder32 upper_adder_c0 (
        .clk   (clk),
        .reset (reset),
        .a     (a[`ADDER_WIDTH-1:`ADDER_HALF_WIDTH]),
        .b     (b[`ADDER_WIDTH-1:`ADDER_HALF_WIDTH]),
        .cin   (1'b0),
        .sum   (sum_high_c0),
        .cout  (cout_high_c0)
    );

    prefix_adder32 upper_adder_c1 (
        .clk   (clk),
        .reset (reset),
        .a     (a[`ADDER_WIDTH-1:`ADDER_HALF_WIDTH]),
        .b     (b[`ADDER_WIDTH-1:`ADDER_HALF_WIDTH]),
        .cin   (1'b1),
        .sum   (sum_high_c1),
        .cout  (cout_high_c1)
    );

    // same latency in all three lanes, so cout_low belongs to the same item
    assign sum  = {cout_low ? sum_high_c1 : sum_high_c0, sum_low};
    assign cout = cout_low ? cout_high_c1 : cout_high_c0;

endmodule

/* test/adder64_props.sv */
`timescale 1ns/1ps
`include "adder_config.svh"

module adder64_props (
    input logic                    clk,
    input logic                    reset,
    input logic [`ADDER_WIDTH-1:0] a,
    input logic [`ADDER_WIDTH-1:0] b,
    input logic                    cin,
    input logic [`ADDER_WIDTH-1:0] sum,
    input logic                    cout
);

    logic [`ADDER_WIDTH:0] total;
    logic                  reset_seen = 1'b0;
    int unsigned           quiet_cycles = 0;

    assign total = {1'b0, a} + {1'b0, b} + {{`ADDER_WIDTH{1'b0}}, cin};

    // edges with reset low since the last reset, saturating at the depth
    always @(posedge clk)
    begin
        if (reset)
        begin
            reset_seen   <= 1'b1;
            quiet_cycles <= 0;
        end
        else if (reset_seen && quiet_cycles < `ADDER_PIPE_DEPTH)
        begin
            quiet_cycles <= quiet_cycles + 1;
        end
    end

    sum_follows_inputs: assert property (@(posedge clk)
        (quiet_cycles >= `ADDER_PIPE_DEPTH) |-> ({cout, sum} == $past(total, `ADDER_PIPE_DEPTH)))
        else $error("sum does not match the operands from %0d cycles back", `ADDER_PIPE_DEPTH);

    zero_after_reset: assert property (@(posedge clk)
        $past(reset) |-> (sum == '0 && cout == 1'b0))
        else $error("outputs not cleared after reset");

endmodule

/* test/adder64_tb.sv */
`timescale 1ns/1ps
`include "adder_config.svh"

module adder64_tb;

    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_COUNT = 2000;
    // reset, about 2100 stimulus cycles and the drain, with headroom
    localparam int MAX_CYCLES = 3000;
    localparam logic [31:0] RAND_SEED = 32'h8aeb40bc;

    localparam logic [`ADDER_WIDTH-1:0] FULL_ONES = {`ADDER_WIDTH{1'b1}};
    localparam logic [`ADDER_HALF_WIDTH-1:0] LOW_ONES = {`ADDER_HALF_WIDTH{1'b1}};
    localparam logic [`ADDER_HALF_WIDTH-1:0] LOW_ZERO = {`ADDER_HALF_WIDTH{1'b0}};
    localparam logic [`ADDER_HALF_WIDTH-1:0] LOW_MSB = LOW_ONES ^ (LOW_ONES >> 1);

    logic                    clk;
    logic                    reset;
    logic [`ADDER_WIDTH-1:0] a;
    logic [`ADDER_WIDTH-1:0] b;
    logic                    cin;
    logic [`ADDER_WIDTH-1:0] sum;
    logic                    cout;

    // one entry per driven cycle, front is the oldest still in flight
    logic [`ADDER_WIDTH-1:0] q_a [$];
    logic [`ADDER_WIDTH-1:0] q_b [$];
    logic                    q_cin [$];
    logic                    q_reset [$];
    string                   q_name [$];

    int cycle_count = 0;

    adder64_top i_adder64_top (
        .clk   (clk),
        .reset (reset),
        .a     (a),
        .b     (b),
        .cin   (cin),
        .sum   (sum),
        .cout  (cout)
    );

    bind adder64_top adder64_props i_adder64_props (
        .clk   (clk),
        .reset (reset),
        .a     (a),
        .b     (b),
        .cin   (cin),
        .sum   (sum),
        .cout  (cout)
    );

    always #5 clk = ~clk;

    // full-width sum, top bit is the carry out
    function automatic logic [`ADDER_WIDTH:0] expected_sum(
        input logic [`ADDER_WIDTH-1:0] x,
        input logic [`ADDER_WIDTH-1:0] y,
        input logic                    c
    );
        return {1'b0, x} + {1'b0, y} + {{`ADDER_WIDTH{1'b0}}, c};
    endfunction

    function automatic logic [`ADDER_WIDTH-1:0] random_word();
        return {$urandom, $urandom};
    endfunction

    function automatic logic random_bit();
        logic [31:0] r;
        r = $urandom;
        return r[0];
    endfunction

    task automatic check_value(
        input string                 name,
        input logic [`ADDER_WIDTH:0] expected,
        input logic [`ADDER_WIDTH:0] actual
    );
        if (actual !== expected)
        begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "result mismatch in %s", name);
        end
    endtask

    task automatic apply(
        input string                   name,
        input logic                    rst,
        input logic [`ADDER_WIDTH-1:0] x,
        input logic [`ADDER_WIDTH-1:0] y,
        input logic                    c
    );
        @(posedge clk);
        reset <= rst;
        a     <= x;
        b     <= y;
        cin   <= c;
        q_a.push_back(x);
        q_b.push_back(y);
        q_cin.push_back(c);
        q_reset.push_back(rst);
        q_name.push_back(name);
    endtask

    // output after edge n belongs to the entry driven at edge n - depth
    always @(negedge clk)
    begin : compare_results
        logic [`ADDER_WIDTH:0] expected;
        logic                  window_reset;
        string                 name;
        if (q_reset.size() == `ADDER_PIPE_DEPTH + 1)
        begin
            window_reset = 1'b0;
            for (int i = 0; i < `ADDER_PIPE_DEPTH; i++)
                window_reset = window_reset | q_reset[i];
            // a reset in flight flushes the older entry, outputs read zero
            if (window_reset)
            begin
                expected = '0;
                name = "reset_flush";
            end
            else
            begin
                expected = expected_sum(q_a[0], q_b[0], q_cin[0]);
                name = q_name[0];
            end
            check_value(name, expected, {cout, sum});
            void'(q_a.pop_front());
            void'(q_b.pop_front());
            void'(q_cin.pop_front());
            void'(q_reset.pop_front());
            void'(q_name.pop_front());
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles, the stimulus did not complete", cycle_count);
            $display("Simulation finished: FAIL");
            $fatal(1, "run exceeded its cycle limit");
        end
    end

    initial
    begin
        logic [`ADDER_HALF_WIDTH-1:0] high_halves [0:4];
        int unsigned                  seed_state;
        clk   = 1'b0;
        reset = 1'b1;
        a     = '0;
        b     = '0;
        cin   = 1'b0;
        seed_state = $urandom(RAND_SEED);

        high_halves[0] = LOW_ZERO;
        high_halves[1] = LOW_ONES;
        high_halves[2] = LOW_ONES >> 1;
        high_halves[3] = LOW_MSB;
        high_halves[4] = $urandom;

        // the initial value counts as the first reset cycle
        repeat (RESET_CYCLES - 1)
            apply("reset", 1'b1, '0, '0, 1'b0);
        apply("idle", 1'b0, '0, '0, 1'b0);
        @(negedge clk);
        check_value("reset_clear", '0, {cout, sum});

        for (int n = 0; n < RANDOM_COUNT / 2; n++)
            apply("random", 1'b0, random_word(), random_word(), random_bit());
        repeat (2)
            apply("mid_reset", 1'b1, random_word(), random_word(), random_bit());
        for (int n = 0; n < RANDOM_COUNT / 2; n++)
            apply("after_reset", 1'b0, random_word(), random_word(), random_bit());

        // carry rippling through the whole word
        apply("chain_cin1", 1'b0, FULL_ONES, '0, 1'b1);
        apply("chain_cin0", 1'b0, FULL_ONES, '0, 1'b0);
        apply("chain_swap", 1'b0, '0, FULL_ONES, 1'b1);
        apply("alternate", 1'b0, 64'h5555_5555_5555_5555, 64'haaaa_aaaa_aaaa_aaaa, 1'b1);
        apply("alternate", 1'b0, 64'haaaa_aaaa_aaaa_aaaa, 64'h5555_5555_5555_5555, 1'b0);
        apply("alternate", 1'b0, 64'h3333_3333_3333_3333, 64'hcccc_cccc_cccc_cccc, 1'b1);
        for (int k = 0; k < `ADDER_WIDTH; k++)
            apply("chain_length", 1'b0, FULL_ONES >> k, 64'd1, 1'b0);

        for (int j = 0; j < 5; j++)
        begin
            apply("carry_into_upper", 1'b0, {high_halves[j], LOW_ONES},
                  {~high_halves[j], LOW_ZERO}, 1'b1);
            apply("carry_into_upper", 1'b0, {high_halves[j], LOW_MSB},
                  {high_halves[j], LOW_MSB}, 1'b0);
            apply("no_carry_into_upper", 1'b0, {high_halves[j], LOW_ONES},
                  {~high_halves[j], LOW_ZERO}, 1'b0);
            apply("no_carry_into_upper", 1'b0, {high_halves[j], LOW_ZERO},
                  {high_halves[j], LOW_ONES}, 1'b0);
        end

        repeat (`ADDER_PIPE_DEPTH)
            apply("drain", 1'b0, '0, '0, 1'b0);
        @(negedge clk);
        @(posedge clk);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* adder64.f */
+incdir+common
common/adder_pkg.sv
common/prefix_stage_if.sv
prefix_adder/status_encoder.sv
prefix_adder/prefix_stage.sv
prefix_adder/prefix_adder32.sv
rtl/adder64_top.sv
test/adder64_props.sv
test/adder64_tb.sv
